//--- common/video_pkg.sv
package video_pkg;

   // ========================================================================
   // pixel format
   // ========================================================================

   localparam int color_w = 8;             // one colour plane, one byte
   localparam int pixel_w = 3 * color_w;   // red high, green mid, blue low

   // pixel and line counters of the timing generator
   // 12 bits covers totals up to 4095
   localparam int cnt_w = 12;

   // ========================================================================
   // default video timing, 320x240 with small porches
   // ========================================================================

   // horizontal, in pixels
   localparam int def_h_active = 320;
   localparam int def_h_front  = 8;        // front porch
   localparam int def_h_sync   = 32;       // sync width
   localparam int def_h_back   = 40;       // back porch

   // vertical, in lines
   localparam int def_v_active = 240;
   localparam int def_v_front  = 3;
   localparam int def_v_sync   = 4;
   localparam int def_v_back   = 6;

   // line total 400 pixels, frame total 253 lines
   // at a 25 MHz pixel clock this is a bit under 250 frames per second

endpackage

//--- src/byte_unpack.sv
`timescale 1ns/1ps

// byte stream to three plane write ports
// byte order per pixel is red, green, blue
module byte_unpack #(
   parameter int pix_count = 76800,   // pixels per frame
   parameter int addr_w    = 17       // plane address width
) (
   input  logic                          dclk,
   input  logic                          rst_n,
   input  logic [video_pkg::color_w-1:0] data_in,
   input  logic                          data_en,
   output logic [addr_w-1:0]             wr_addr,
   output logic [video_pkg::color_w-1:0] wr_data,
   output logic                          wea_r,
   output logic                          wea_g,
   output logic                          wea_b
);

   localparam logic [addr_w-1:0] last_addr = addr_w'(pix_count - 1);

   logic [1:0]        plane_q;   // 0 red, 1 green, 2 blue
   logic [addr_w-1:0] pix_q;     // pixel the next byte belongs to

   // ========================================================================
   // position in the stream, counted from reset only
   // ========================================================================

   always_ff @(posedge dclk or negedge rst_n) begin
      if (!rst_n) begin
         plane_q <= 2'd0;
         pix_q   <= '0;
      end else if (data_en) begin        // idle cycles leave the count alone
         if (plane_q == 2'd2) begin      // blue closes the pixel
            plane_q <= 2'd0;
            pix_q   <= (pix_q == last_addr) ? '0 : pix_q + 1'b1;   // wrap at frame end
         end else begin
            plane_q <= plane_q + 2'd1;
         end
      end
   end

   // ========================================================================
   // write port, one cycle behind the accepted byte
   // ========================================================================

   always_ff @(posedge dclk or negedge rst_n) begin
      if (!rst_n) begin
         wea_r   <= 1'b0;
         wea_g   <= 1'b0;
         wea_b   <= 1'b0;
         wr_addr <= '0;
      end else begin
         wea_r <= data_en && (plane_q == 2'd0);   // one-cycle strobes
         wea_g <= data_en && (plane_q == 2'd1);
         wea_b <= data_en && (plane_q == 2'd2);
         if (data_en) begin
            wr_addr <= pix_q;
         end
      end
   end

   // byte payload
   always_ff @(posedge dclk) begin
      if (data_en) begin
         wr_data <= data_in;
      end
   end

   // a byte lands in exactly one plane
   a_one_plane: assert property (
      @(posedge dclk) disable iff (!rst_n)
      $onehot0({wea_r, wea_g, wea_b})
   );

endmodule

//--- vram/plane_ram.sv
`timescale 1ns/1ps

// one colour plane of the frame
// write port on the byte clock, registered read on the pixel clock
module plane_ram #(
   parameter int pix_count = 76800,
   parameter int addr_w    = 17
) (
   input  logic                          dclk,
   input  logic                          wea,
   input  logic [addr_w-1:0]             wr_addr,
   input  logic [video_pkg::color_w-1:0] wr_data,
   input  logic                          pck,
   input  logic [addr_w-1:0]             rd_addr,
   output logic [video_pkg::color_w-1:0] rd_data
);

   logic [video_pkg::color_w-1:0] mem [pix_count];   // maps to block RAM

   // port A, byte side
   always_ff @(posedge dclk) begin
      if (wea) begin
         mem[wr_addr] <= wr_data;
      end
   end

   // port B, pixel side, data one pck after the address
   always_ff @(posedge pck) begin
      rd_data <= mem[rd_addr];
   end

   // the unpacker must wrap before the end of the plane
   a_wr_range: assert property (
      @(posedge dclk)
      wea |-> (wr_addr < pix_count)
   );

endmodule

//--- video/video_timing.sv
`timescale 1ns/1ps

// free running raster timing on the pixel clock
// all outputs registered from the counters
module video_timing #(
   parameter int h_active = video_pkg::def_h_active,
   parameter int h_front  = video_pkg::def_h_front,
   parameter int h_sync   = video_pkg::def_h_sync,
   parameter int h_back   = video_pkg::def_h_back,
   parameter int v_active = video_pkg::def_v_active,
   parameter int v_front  = video_pkg::def_v_front,
   parameter int v_sync   = video_pkg::def_v_sync,
   parameter int v_back   = video_pkg::def_v_back
) (
   input  logic                        pck,
   input  logic                        rst_n,
   output logic [video_pkg::cnt_w-1:0] h_count,
   output logic [video_pkg::cnt_w-1:0] v_count,
   output logic                        t_de,
   output logic                        t_hsync,
   output logic                        t_vsync
);

   localparam int h_total  = h_active + h_front + h_sync + h_back;
   localparam int v_total  = v_active + v_front + v_sync + v_back;
   localparam int hs_start = h_active + h_front;   // sync follows front porch
   localparam int hs_end   = hs_start + h_sync;
   localparam int vs_start = v_active + v_front;
   localparam int vs_end   = vs_start + v_sync;

   logic [video_pkg::cnt_w-1:0] h_cnt;   // pixel in line
   logic [video_pkg::cnt_w-1:0] v_cnt;   // line in frame
   logic                        de_c;
   logic                        hs_c;
   logic                        vs_c;

   // ========================================================================
   // raster counters
   // ========================================================================

   always_ff @(posedge pck or negedge rst_n) begin
      if (!rst_n) begin
         h_cnt <= '0;
         v_cnt <= '0;
      end else if (h_cnt == h_total - 1) begin   // end of line
         h_cnt <= '0;
         if (v_cnt == v_total - 1) begin         // end of frame
            v_cnt <= '0;
         end else begin
            v_cnt <= v_cnt + 1'b1;
         end
      end else begin
         h_cnt <= h_cnt + 1'b1;
      end
   end

   // window decode
   assign de_c = (h_cnt < h_active) && (v_cnt < v_active);
   assign hs_c = (h_cnt >= hs_start) && (h_cnt < hs_end);
   assign vs_c = (v_cnt >= vs_start) && (v_cnt < vs_end);   // whole lines

   // ========================================================================
   // registered outputs, counts stay aligned with the flags
   // ========================================================================

   always_ff @(posedge pck or negedge rst_n) begin
      if (!rst_n) begin
         h_count <= '0;
         v_count <= '0;
         t_de    <= 1'b0;
         t_hsync <= 1'b0;
         t_vsync <= 1'b0;
      end else begin
         h_count <= h_cnt;
         v_count <= v_cnt;
         t_de    <= de_c;
         t_hsync <= hs_c;
         t_vsync <= vs_c;
      end
   end

   // sync sits in blanking only
   a_de_hsync: assert property (
      @(posedge pck) disable iff (!rst_n)
      !(t_de && t_hsync)
   );

endmodule

//--- video/frame_scanout.sv
`timescale 1ns/1ps

// plane read addressing and output alignment
// t_de to den is two pck, rgb follows den
module frame_scanout #(
   parameter int h_active  = video_pkg::def_h_active,
   parameter int pix_count = 76800,
   parameter int addr_w    = 17
) (
   input  logic                          pck,
   input  logic                          rst_n,
   input  logic [video_pkg::cnt_w-1:0]   h_count,
   input  logic [video_pkg::cnt_w-1:0]   v_count,
   input  logic                          t_de,
   input  logic                          t_hsync,
   input  logic                          t_vsync,
   input  logic [video_pkg::color_w-1:0] rd_r,
   input  logic [video_pkg::color_w-1:0] rd_g,
   input  logic [video_pkg::color_w-1:0] rd_b,
   output logic [addr_w-1:0]             rd_addr,
   output logic [video_pkg::pixel_w-1:0] rgb,
   output logic                          hsync,
   output logic                          vsync,
   output logic                          den
);

   logic [addr_w-1:0] pix_addr;   // line * width + column
   logic              de_q;       // stage one flags
   logic              hs_q;
   logic              vs_q;

   // only meaningful inside the active window
   assign pix_addr = addr_w'(v_count * h_active + h_count);

   // ========================================================================
   // stage one, address to the planes
   // ========================================================================

   always_ff @(posedge pck or negedge rst_n) begin
      if (!rst_n) begin
         rd_addr <= '0;
         de_q    <= 1'b0;
         hs_q    <= 1'b0;
         vs_q    <= 1'b0;
      end else begin
         if (t_de) begin
            rd_addr <= pix_addr;   // held through blanking
         end
         de_q <= t_de;
         hs_q <= t_hsync;
         vs_q <= t_vsync;
      end
   end

   // ========================================================================
   // stage two, flags meet the plane read register
   // ========================================================================

   always_ff @(posedge pck or negedge rst_n) begin
      if (!rst_n) begin
         den   <= 1'b0;
         hsync <= 1'b0;
         vsync <= 1'b0;
      end else begin
         den   <= de_q;
         hsync <= hs_q;
         vsync <= vs_q;
      end
   end

   // black outside the picture
   assign rgb = den ? {rd_r, rd_g, rd_b} : '0;

   // visible pixels must read inside the plane memories
   a_rd_range: assert property (
      @(posedge pck) disable iff (!rst_n)
      de_q |-> (rd_addr < pix_count)
   );

endmodule

//--- src/display_top.sv
`timescale 1ns/1ps

// byte stream in, parallel RGB with syncs out
// ends where the rgb2dvi encoder would start
module display_top #(
   parameter int h_active = video_pkg::def_h_active,
   parameter int h_front  = video_pkg::def_h_front,
   parameter int h_sync   = video_pkg::def_h_sync,
   parameter int h_back   = video_pkg::def_h_back,
   parameter int v_active = video_pkg::def_v_active,
   parameter int v_front  = video_pkg::def_v_front,
   parameter int v_sync   = video_pkg::def_v_sync,
   parameter int v_back   = video_pkg::def_v_back
) (
   input  logic                          dclk,      // byte clock
   input  logic                          pck,       // pixel clock
   input  logic                          rst_n,
   input  logic [video_pkg::color_w-1:0] data_in,
   input  logic                          data_en,
   output logic [video_pkg::pixel_w-1:0] rgb,
   output logic                          hsync,
   output logic                          vsync,
   output logic                          den
);

   localparam int pix_count = h_active * v_active;
   localparam int addr_w    = $clog2(pix_count);

   // ========================================================================
   // byte side, dclk
   // ========================================================================

   logic [addr_w-1:0]             wr_addr;
   logic [video_pkg::color_w-1:0] wr_data;   // shared by all planes
   logic                          wea_r;
   logic                          wea_g;
   logic                          wea_b;

   byte_unpack #(.pix_count(pix_count), .addr_w(addr_w)) i_unpack (
      .dclk, .rst_n, .data_in, .data_en,
      .wr_addr, .wr_data, .wea_r, .wea_g, .wea_b
   );

   // ========================================================================
   // frame memory, one plane per colour
   // ========================================================================

   logic [addr_w-1:0]             rd_addr;
   logic [video_pkg::color_w-1:0] rd_r;
   logic [video_pkg::color_w-1:0] rd_g;
   logic [video_pkg::color_w-1:0] rd_b;

   plane_ram #(.pix_count(pix_count), .addr_w(addr_w)) plane_r (
      .dclk, .wea(wea_r), .wr_addr, .wr_data, .pck, .rd_addr, .rd_data(rd_r)
   );

   plane_ram #(.pix_count(pix_count), .addr_w(addr_w)) plane_g (
      .dclk, .wea(wea_g), .wr_addr, .wr_data, .pck, .rd_addr, .rd_data(rd_g)
   );

   plane_ram #(.pix_count(pix_count), .addr_w(addr_w)) plane_b (
      .dclk, .wea(wea_b), .wr_addr, .wr_data, .pck, .rd_addr, .rd_data(rd_b)
   );

   // ========================================================================
   // pixel side, pck
   // ========================================================================

   logic [video_pkg::cnt_w-1:0] h_count;
   logic [video_pkg::cnt_w-1:0] v_count;
   logic                        t_de;
   logic                        t_hsync;
   logic                        t_vsync;

   video_timing #(
      .h_active(h_active), .h_front(h_front), .h_sync(h_sync), .h_back(h_back),
      .v_active(v_active), .v_front(v_front), .v_sync(v_sync), .v_back(v_back)
   ) i_timing (
      .pck, .rst_n, .h_count, .v_count, .t_de, .t_hsync, .t_vsync
   );

   frame_scanout #(.h_active(h_active), .pix_count(pix_count), .addr_w(addr_w)) i_scanout (
      .pck, .rst_n, .h_count, .v_count, .t_de, .t_hsync, .t_vsync,
      .rd_r, .rd_g, .rd_b, .rd_addr, .rgb, .hsync, .vsync, .den
   );

endmodule

//--- tests/tb_display.sv
`timescale 1ns/1ps

module tb_display;

   // small raster so a frame is only a few hundred cycles
   localparam int h_act        = 16;
   localparam int h_fp         = 2;
   localparam int h_sw         = 3;
   localparam int h_bp         = 2;
   localparam int v_act        = 8;
   localparam int v_fp         = 1;
   localparam int v_sw         = 2;
   localparam int v_bp         = 1;
   localparam int h_total      = h_act + h_fp + h_sw + h_bp;   // 23
   localparam int v_total      = v_act + v_fp + v_sw + v_bp;   // 12
   localparam int frame_cycles = h_total * v_total;           // 276
   localparam int pix_count    = h_act * v_act;               // 128
   localparam int frame_bytes  = 3 * pix_count;

   logic                          dclk = 1'b0;
   logic                          pck  = 1'b0;
   logic                          rst_n;
   logic [video_pkg::color_w-1:0] data_in;
   logic                          data_en;
   logic [video_pkg::pixel_w-1:0] rgb;
   logic                          hsync;
   logic                          vsync;
   logic                          den;

   logic [video_pkg::color_w-1:0] sent [$];   // every byte, in stream order
   integer seed;
   int     errors       = 0;
   int     check_count  = 0;
   int     timeouts     = 0;
   int     test_count   = 0;
   int     failed_tests = 0;

   // comparing process state
   logic vs_prev      = 1'b0;
   logic active       = 1'b0;   // frame under check
   int   arm_count    = 0;      // frames requested by the stimulus
   int   start_count  = 0;
   int   done_count   = 0;
   int   frame_pix    = 0;
   int   pix_idx      = 0;      // den cycles since vsync
   int   blank_cycles = 0;
   int   blank_errs   = 0;

   display_top #(
      .h_active(h_act), .h_front(h_fp), .h_sync(h_sw), .h_back(h_bp),
      .v_active(v_act), .v_front(v_fp), .v_sync(v_sw), .v_back(v_bp)
   ) i_dut (
      .dclk, .pck, .rst_n, .data_in, .data_en, .rgb, .hsync, .vsync, .den
   );

   // ========================================================================
   // clocks, pck rises 3 ns after dclk
   // ========================================================================

   always #4 dclk = ~dclk;

   always begin
      #3 pck = 1'b0;
      #4 pck = 1'b1;
      #1;
   end

   // ========================================================================
   // helpers
   // ========================================================================

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
      check_count = check_count + 1;
      if (got !== exp) begin
         errors = errors + 1;
         $display("FAIL %s: got 0x%0h, expected 0x%0h", name, got, exp);
      end
   endtask

   task automatic note_timeout(input string what);
      timeouts = timeouts + 1;
      $display("timeout: no %s within the expected time", what);
   endtask

   // expected pixel from the last three bytes that landed on this index
   function automatic logic [video_pkg::pixel_w-1:0] pixel_ref(input int index);
      logic [video_pkg::color_w-1:0] r;
      logic [video_pkg::color_w-1:0] g;
      logic [video_pkg::color_w-1:0] b;
      int                            k;
      r = '0;
      g = '0;
      b = '0;
      for (k = 0; k < sent.size(); k++) begin
         if ((k / 3) % pix_count == index) begin   // byte position wraps per frame
            case (k % 3)
               0:       r = sent[k];
               1:       g = sent[k];
               default: b = sent[k];
            endcase
         end
      end
      return {r, g, b};
   endfunction

   task automatic outputs_quiet();
      check_value("den", 32'(den), 32'h0);
      check_value("hsync", 32'(hsync), 32'h0);
      check_value("vsync", 32'(vsync), 32'h0);
      check_value("rgb", 32'(rgb), 32'h0);
   endtask

   task automatic wait_vsync_rise(input string what);
      int   n;
      logic prev;
      logic found;
      n     = 0;
      found = 1'b0;
      @(negedge pck);
      prev = vsync;
      while (!found && n < 2 * frame_cycles) begin
         @(negedge pck);
         n     = n + 1;
         found = vsync && !prev;
         prev  = vsync;
      end
      if (!found) begin
         note_timeout(what);
      end
   endtask

   // bytes on dclk, optionally with 0 to 3 idle cycles before each
   task automatic send_bytes(input int count, input bit gaps);
      logic [31:0] rnd;
      int          i;
      for (i = 0; i < count; i++) begin
         if (gaps) begin
            rnd = $random(seed);
            repeat (rnd[1:0]) begin
               @(posedge dclk);
               data_en <= 1'b0;
            end
         end
         rnd = $random(seed);
         @(posedge dclk);
         data_in <= rnd[7:0];
         data_en <= 1'b1;
         sent.push_back(rnd[7:0]);
      end
      @(posedge dclk);
      data_en <= 1'b0;
   endtask

   // hand one whole frame to the comparing process and wait until it is done
   task automatic scan_next_frame(input string what);
      int n;
      repeat (3) @(posedge dclk);   // strobe cycle plus the RAM write
      arm_count = arm_count + 1;
      n = 0;
      while (done_count < arm_count && n < 3 * frame_cycles) begin
         @(posedge dclk);
         n = n + 1;
      end
      if (done_count < arm_count) begin
         note_timeout(what);
      end else begin
         check_value("pixels per frame", frame_pix, pix_count);
      end
   endtask

   task automatic measure_geometry();
      int   cyc;
      int   den_run;
      int   den_lines;
      int   hs_run;
      int   hs_pulses;
      int   last_hs;
      int   vs_high;
      logic den_p;
      logic hs_p;
      logic vs_p;
      logic done;
      wait_vsync_rise("vsync pulse before the geometry frame");
      cyc       = 0;
      den_run   = 0;
      den_lines = 0;
      hs_run    = 0;
      hs_pulses = 0;
      last_hs   = -1;
      vs_high   = 1;                // rising cycle itself
      den_p     = den;
      hs_p      = hsync;
      vs_p      = vsync;
      done      = 1'b0;
      while (!done && cyc < 2 * frame_cycles) begin
         @(negedge pck);
         cyc = cyc + 1;
         if (den) begin
            den_run = den_run + 1;
         end else if (den_p) begin   // end of an active line
            check_value("den run length", den_run, h_act);
            den_lines = den_lines + 1;
            den_run   = 0;
         end
         if (hsync) begin
            hs_run = hs_run + 1;
            if (!hs_p) begin
               if (last_hs >= 0) begin
                  check_value("hsync period", cyc - last_hs, h_total);
               end
               last_hs   = cyc;
               hs_pulses = hs_pulses + 1;
            end
         end else if (hs_p) begin
            check_value("hsync width", hs_run, h_sw);
            hs_run = 0;
         end
         if (vsync && !vs_p) begin
            check_value("vsync period", cyc, frame_cycles);
            done = 1'b1;
         end else if (vsync) begin
            vs_high = vs_high + 1;
         end
         den_p = den;
         hs_p  = hsync;
         vs_p  = vsync;
      end
      if (!done) begin
         note_timeout("second vsync pulse");
      end else begin
         check_value("den lines per frame", den_lines, v_act);
         check_value("hsync pulses per frame", hs_pulses, v_total);
         check_value("vsync width", vs_high, v_sw * h_total);
      end
   endtask

   task automatic report_test(input string name, input int errs_before);
      test_count = test_count + 1;
      if (errors == errs_before) begin
         $display("test %0d %s: ok", test_count, name);
      end else begin
         failed_tests = failed_tests + 1;
         $display("test %0d %s: %0d errors", test_count, name, errors - errs_before);
      end
   endtask

   // ========================================================================
   // comparing process, one frame at a time from vsync to vsync
   // ========================================================================

   always @(negedge pck) begin
      if (rst_n) begin
         if (vsync && !vs_prev) begin
            pix_idx = 0;
            if (active) begin
               active     = 1'b0;
               done_count = done_count + 1;
            end else if (start_count < arm_count) begin
               start_count = start_count + 1;
               active      = 1'b1;
               frame_pix   = 0;
            end
         end
         if (active) begin
            if (den) begin
               check_value("rgb", 32'(rgb), 32'(pixel_ref(pix_idx)));
               frame_pix = frame_pix + 1;
            end else begin
               blank_cycles = blank_cycles + 1;
               if (rgb != '0) begin
                  blank_errs = blank_errs + 1;
               end
               check_value("rgb while den low", 32'(rgb), 32'h0);
            end
         end
         if (den) begin
            pix_idx = pix_idx + 1;
         end
      end
      vs_prev = vsync;
   end

   // ========================================================================
   // stimulus
   // ========================================================================

   initial begin
      int   errs0;
      int   i;
      int   n;
      logic seen;
      rst_n   = 1'b0;
      data_in = '0;
      data_en = 1'b0;
      seed    = 32'h704d6ddc;

      // test 1, quiet outputs in reset and right after it
      errs0 = errors;
      for (i = 0; i < 5; i++) begin
         @(posedge dclk);
         @(negedge pck);
         outputs_quiet();
      end
      @(posedge dclk);
      rst_n <= 1'b1;
      n    = 0;
      seen = 1'b0;
      while (!seen && n < 8) begin
         @(posedge pck);
         n = n + 1;
         @(negedge pck);
         if (n == 1) begin
            outputs_quiet();
         end
         seen = den;
      end
      if (!seen) begin
         note_timeout("den after reset");
      end else begin
         check_value("den latency after reset", n, 3);   // timing, stage one, stage two
      end
      report_test("reset state", errs0);

      errs0 = errors;
      measure_geometry();
      report_test("sync geometry", errs0);

      errs0 = errors;
      send_bytes(frame_bytes, 1'b0);
      scan_next_frame("end of the full image frame");
      report_test("full image", errs0);

      errs0 = errors;
      send_bytes(frame_bytes, 1'b1);
      scan_next_frame("end of the gapped stream frame");
      report_test("gaps in the stream", errs0);

      errs0 = errors;
      send_bytes(30, 1'b0);   // pixels 0 to 9 only
      scan_next_frame("end of the wrap frame");
      report_test("address wrap", errs0);

      // blanking was checked by the comparing process during tests 3 to 5
      test_count = test_count + 1;
      if (blank_cycles == 0) begin
         errors       = errors + 1;
         failed_tests = failed_tests + 1;
         $display("test %0d blanking: no blanking cycles were checked", test_count);
      end else if (blank_errs != 0) begin
         failed_tests = failed_tests + 1;
         $display("test %0d blanking: %0d of %0d cycles not black",
                  test_count, blank_errs, blank_cycles);
      end else begin
         $display("test %0d blanking: ok, %0d cycles", test_count, blank_cycles);
      end

      $display("%0d tests, %0d failed, %0d checks, %0d errors, %0d timeouts",
               test_count, failed_tests, check_count, errors, timeouts);
      if (errors == 0 && timeouts == 0) begin
         $display("Simulation passed");
      end else begin
         $display("Simulation failed");
      end
      $finish;
   end

endmodule

//--- verilog.f
common/video_pkg.sv
src/byte_unpack.sv
vram/plane_ram.sv
video/video_timing.sv
video/frame_scanout.sv
src/display_top.sv
tests/tb_display.sv

//--- Makefile
TOOL       = verilator
TOP        = tb_display
FLIST      = verilog.f
FLAGS      = --binary --timing --assert -j 0
LINT_FLAGS = --lint-only --timing -Wall
BUILD      = obj_dir
LOG        = sim.log

SRCS = $(shell grep -v '^+' $(FLIST))

.PHONY: all run lint clean

all: run

$(BUILD)/V$(TOP): $(FLIST) $(SRCS)
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FLIST)

run: $(BUILD)/V$(TOP)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	@grep -q "Simulation passed" $(LOG) || (echo "run failed, see $(LOG)"; exit 1)

lint:
	$(TOOL) $(LINT_FLAGS) --top-module $(TOP) -f $(FLIST)
	$(TOOL) $(LINT_FLAGS) --top-module display_top common/video_pkg.sv \
		src/byte_unpack.sv vram/plane_ram.sv video/video_timing.sv \
		video/frame_scanout.sv src/display_top.sv

clean:
	rm -rf $(BUILD) $(LOG)
